// ==== verilog/cart_pkg.sv ====
package cart_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Bus widths
   ////////////////////////////////////////////////////////////////////////////

   // Byte address seen by console and MCU
   localparam int ADDR_W = 20;
   // Console and MCU data byte
   localparam int DATA_W = 8;
   // External SRAM word
   localparam int SRAM_W = 16;

   ////////////////////////////////////////////////////////////////////////////
   // Timing
   ////////////////////////////////////////////////////////////////////////////

   // Cycles the SRAM controls stay asserted per access
   localparam int SRAM_WAIT = 3;
   // Wait counter width, must hold SRAM_WAIT-1
   localparam int WAIT_W = $clog2(SRAM_WAIT + 1);
   // Console strobe synchronizer depth
   localparam int SYNC_STAGES = 2;

   // SRAM owner select
   localparam logic MODE_SNES = 1'b0;
   localparam logic MODE_MCU  = 1'b1;

   // Byte enables, active low, bit 1 = high byte
   localparam logic [1:0] SRAM_BE_NONE = 2'b11;
   localparam logic [1:0] SRAM_BE_LO   = 2'b10;
   localparam logic [1:0] SRAM_BE_HI   = 2'b01;

endpackage

// ==== verilog/cart_data_path.sv ====
module cart_data_path (
   input  logic                          CLK,
   input  logic                          rst_n,
   // Latch load pulses from the sequencer
   input  logic                          snes_to_latch,
   input  logic                          mcu_to_latch,
   input  logic                          sram_to_snes_latch,
   input  logic                          sram_to_mcu_latch,
   // Access attributes
   input  logic                          lane_odd,
   input  logic                          wr_from_mcu,
   input  logic                          sram_dq_oe_req,
   // Console side
   input  logic                          snes_rd_n,
   input  logic [cart_pkg::DATA_W-1:0]   snes_data_in,
   output logic [cart_pkg::DATA_W-1:0]   snes_data_out,
   output logic                          snes_data_oe,
   // MCU side
   input  logic [cart_pkg::DATA_W-1:0]   mcu_wdata,
   output logic [cart_pkg::DATA_W-1:0]   mcu_rdata,
   // SRAM side
   input  logic [cart_pkg::SRAM_W-1:0]   sram_dq_in,
   output logic [cart_pkg::SRAM_W-1:0]   sram_dq_out,
   output logic                          sram_dq_oe
);
   import cart_pkg::*;

   // Byte latches
   logic [DATA_W-1:0] snes_in_q;
   logic [DATA_W-1:0] snes_out_q;
   logic [DATA_W-1:0] mcu_in_q;
   logic [DATA_W-1:0] mcu_out_q;

   // Steered bytes
   logic [DATA_W-1:0] sram_rd_byte;
   logic [DATA_W-1:0] sram_wr_byte;

   ////////////////////////////////////////////////////////////////////////////
   // Lane steering
   ////////////////////////////////////////////////////////////////////////////

   // Odd address -> low half, even address -> high half
   assign sram_rd_byte = lane_odd ? sram_dq_in[DATA_W-1:0]
                                  : sram_dq_in[SRAM_W-1:DATA_W];

   // Write source picked by the side that started the access
   assign sram_wr_byte = wr_from_mcu ? mcu_in_q : snes_in_q;

   // Same byte on both halves, byte enables pick the lane
   assign sram_dq_out = {sram_wr_byte, sram_wr_byte};
   assign sram_dq_oe  = sram_dq_oe_req;

   ////////////////////////////////////////////////////////////////////////////
   // Bus drive
   ////////////////////////////////////////////////////////////////////////////

   // Console bus driven for as long as the read strobe is low
   assign snes_data_oe  = ~snes_rd_n;
   assign snes_data_out = snes_out_q;

   // MCU sees the last read byte
   assign mcu_rdata = mcu_out_q;

   ////////////////////////////////////////////////////////////////////////////
   // Latches
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         snes_in_q  <= '0;
         snes_out_q <= '0;
         mcu_in_q   <= '0;
         mcu_out_q  <= '0;
      end else begin
         // Write data in from either side
         if (snes_to_latch)
            snes_in_q <= snes_data_in;
         if (mcu_to_latch)
            mcu_in_q <= mcu_wdata;
         // Read data back from SRAM
         if (sram_to_snes_latch)
            snes_out_q <= sram_rd_byte;
         if (sram_to_mcu_latch)
            mcu_out_q <= sram_rd_byte;
      end
   end

endmodule

// ==== verilog/cart_mem_sequencer.sv ====
module cart_mem_sequencer (
   input  logic                          CLK,
   input  logic                          rst_n,
   input  logic                          mode,
   // Console strobes, asynchronous
   input  logic                          snes_rd_n,
   input  logic                          snes_wr_n,
   input  logic [cart_pkg::ADDR_W-1:0]   snes_addr,
   // MCU request pulses
   input  logic                          mcu_rd,
   input  logic                          mcu_wr,
   input  logic [cart_pkg::ADDR_W-1:0]   mcu_addr,
   // SRAM controls
   output logic [cart_pkg::ADDR_W-2:0]   sram_addr,
   output logic                          sram_ce_n,
   output logic                          sram_oe_n,
   output logic                          sram_we_n,
   output logic [1:0]                    sram_be_n,
   output logic                          sram_dq_oe_req,
   // Data path control
   output logic                          snes_to_latch,
   output logic                          mcu_to_latch,
   output logic                          sram_to_snes_latch,
   output logic                          sram_to_mcu_latch,
   output logic                          lane_odd,
   output logic                          wr_from_mcu,
   output logic                          mcu_done
);
   import cart_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_ACCESS,
      ST_FINISH
   } state_t;

   state_t state;

   // Strobe synchronizers and edge detect
   logic [SYNC_STAGES-1:0] rd_sync;
   logic [SYNC_STAGES-1:0] wr_sync;
   logic rd_prev;
   logic wr_prev;
   logic snes_rd_fall;
   logic snes_wr_fall;

   // Request gating
   logic snes_own;
   logic mcu_own;
   logic idle;
   logic snes_start;
   logic mcu_start;
   logic start;
   logic start_rd;
   logic [ADDR_W-1:0] start_addr;

   // Access in flight
   logic [WAIT_W-1:0] wait_cnt;
   logic acc_rd;
   logic acc_mcu;
   logic load_next;
   logic load_mcu_next;

   ////////////////////////////////////////////////////////////////////////////
   // Console strobe sync
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         rd_sync <= '1;
         wr_sync <= '1;
         rd_prev <= 1'b1;
         wr_prev <= 1'b1;
      end else begin
         rd_sync <= {rd_sync[SYNC_STAGES-2:0], snes_rd_n};
         wr_sync <= {wr_sync[SYNC_STAGES-2:0], snes_wr_n};
         rd_prev <= rd_sync[SYNC_STAGES-1];
         wr_prev <= wr_sync[SYNC_STAGES-1];
      end
   end

   // High for one cycle on a synced falling edge
   assign snes_rd_fall = rd_prev & ~rd_sync[SYNC_STAGES-1];
   assign snes_wr_fall = wr_prev & ~wr_sync[SYNC_STAGES-1];

   ////////////////////////////////////////////////////////////////////////////
   // Request gating
   ////////////////////////////////////////////////////////////////////////////

   assign snes_own = (mode == MODE_SNES);
   assign mcu_own  = (mode == MODE_MCU);
   assign idle     = (state == ST_IDLE);

   // Non-owner requests and requests while busy are dropped
   assign snes_start = idle && snes_own && (snes_rd_fall || snes_wr_fall);
   assign mcu_start  = idle && mcu_own && (mcu_rd || mcu_wr);
   assign start      = snes_start || mcu_start;

   // Read wins if both console strobes fall together
   assign start_rd   = mcu_start ? mcu_rd : snes_rd_fall;
   assign start_addr = mcu_start ? mcu_addr : snes_addr;

   // Write data captured on the edge that starts the access
   assign snes_to_latch = snes_start && !snes_rd_fall;
   assign mcu_to_latch  = mcu_start && !mcu_rd;

   // Read latch pulse lands in the last wait cycle
   assign load_next = start ? (start_rd && SRAM_WAIT == 1)
                            : (state == ST_ACCESS && acc_rd && wait_cnt == WAIT_W'(1));
   assign load_mcu_next = start ? mcu_start : acc_mcu;

   ////////////////////////////////////////////////////////////////////////////
   // SRAM cycle FSM
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         state              <= ST_IDLE;
         wait_cnt           <= '0;
         acc_rd             <= 1'b0;
         acc_mcu            <= 1'b0;
         sram_addr          <= '0;
         lane_odd           <= 1'b0;
         wr_from_mcu        <= 1'b0;
         sram_ce_n          <= 1'b1;
         sram_oe_n          <= 1'b1;
         sram_we_n          <= 1'b1;
         sram_be_n          <= SRAM_BE_NONE;
         sram_dq_oe_req     <= 1'b0;
         sram_to_snes_latch <= 1'b0;
         sram_to_mcu_latch  <= 1'b0;
         mcu_done           <= 1'b0;
      end else begin
         sram_to_snes_latch <= load_next && !load_mcu_next;
         sram_to_mcu_latch  <= load_next && load_mcu_next;
         mcu_done           <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (start) begin
                  state          <= ST_ACCESS;
                  wait_cnt       <= WAIT_W'(SRAM_WAIT - 1);
                  acc_rd         <= start_rd;
                  acc_mcu        <= mcu_start;
                  wr_from_mcu    <= mcu_start;
                  // Word address, bit 0 picks the lane
                  sram_addr      <= start_addr[ADDR_W-1:1];
                  lane_odd       <= start_addr[0];
                  sram_ce_n      <= 1'b0;
                  sram_oe_n      <= ~start_rd;
                  sram_we_n      <= start_rd;
                  sram_be_n      <= start_addr[0] ? SRAM_BE_LO : SRAM_BE_HI;
                  sram_dq_oe_req <= ~start_rd;
               end
            end
            ST_ACCESS: begin
               if (wait_cnt == '0) begin
                  // Rising we_n here commits a write
                  state          <= ST_FINISH;
                  sram_ce_n      <= 1'b1;
                  sram_oe_n      <= 1'b1;
                  sram_we_n      <= 1'b1;
                  sram_be_n      <= SRAM_BE_NONE;
                  sram_dq_oe_req <= 1'b0;
                  mcu_done       <= acc_mcu;
               end else begin
                  wait_cnt <= wait_cnt - 1'b1;
               end
            end
            // One idle cycle between accesses
            ST_FINISH: state <= ST_IDLE;
            default:   state <= ST_IDLE;
         endcase
      end
   end

endmodule

// ==== verilog/cart_mem_top.sv ====
module cart_mem_top (
   input  logic                          CLK,
   input  logic                          rst_n,
   input  logic                          mode,
   // Console side
   input  logic                          snes_rd_n,
   input  logic                          snes_wr_n,
   input  logic [cart_pkg::ADDR_W-1:0]   snes_addr,
   input  logic [cart_pkg::DATA_W-1:0]   snes_data_in,
   output logic [cart_pkg::DATA_W-1:0]   snes_data_out,
   output logic                          snes_data_oe,
   // MCU side
   input  logic                          mcu_rd,
   input  logic                          mcu_wr,
   input  logic [cart_pkg::ADDR_W-1:0]   mcu_addr,
   input  logic [cart_pkg::DATA_W-1:0]   mcu_wdata,
   output logic [cart_pkg::DATA_W-1:0]   mcu_rdata,
   output logic                          mcu_done,
   // SRAM side
   output logic [cart_pkg::ADDR_W-2:0]   sram_addr,
   output logic                          sram_ce_n,
   output logic                          sram_oe_n,
   output logic                          sram_we_n,
   output logic [1:0]                    sram_be_n,
   output logic [cart_pkg::SRAM_W-1:0]   sram_dq_out,
   output logic                          sram_dq_oe,
   input  logic [cart_pkg::SRAM_W-1:0]   sram_dq_in
);

   // Sequencer to data path
   logic snes_to_latch;
   logic mcu_to_latch;
   logic sram_to_snes_latch;
   logic sram_to_mcu_latch;
   logic lane_odd;
   logic wr_from_mcu;
   logic sram_dq_oe_req;

   cart_mem_sequencer i_seq (
      .CLK                (CLK),
      .rst_n              (rst_n),
      .mode               (mode),
      .snes_rd_n          (snes_rd_n),
      .snes_wr_n          (snes_wr_n),
      .snes_addr          (snes_addr),
      .mcu_rd             (mcu_rd),
      .mcu_wr             (mcu_wr),
      .mcu_addr           (mcu_addr),
      .sram_addr          (sram_addr),
      .sram_ce_n          (sram_ce_n),
      .sram_oe_n          (sram_oe_n),
      .sram_we_n          (sram_we_n),
      .sram_be_n          (sram_be_n),
      .sram_dq_oe_req     (sram_dq_oe_req),
      .snes_to_latch      (snes_to_latch),
      .mcu_to_latch       (mcu_to_latch),
      .sram_to_snes_latch (sram_to_snes_latch),
      .sram_to_mcu_latch  (sram_to_mcu_latch),
      .lane_odd           (lane_odd),
      .wr_from_mcu        (wr_from_mcu),
      .mcu_done           (mcu_done)
   );

   cart_data_path i_data (
      .CLK                (CLK),
      .rst_n              (rst_n),
      .snes_to_latch      (snes_to_latch),
      .mcu_to_latch       (mcu_to_latch),
      .sram_to_snes_latch (sram_to_snes_latch),
      .sram_to_mcu_latch  (sram_to_mcu_latch),
      .lane_odd           (lane_odd),
      .wr_from_mcu        (wr_from_mcu),
      .sram_dq_oe_req     (sram_dq_oe_req),
      .snes_rd_n          (snes_rd_n),
      .snes_data_in       (snes_data_in),
      .snes_data_out      (snes_data_out),
      .snes_data_oe       (snes_data_oe),
      .mcu_wdata          (mcu_wdata),
      .mcu_rdata          (mcu_rdata),
      .sram_dq_in         (sram_dq_in),
      .sram_dq_out        (sram_dq_out),
      .sram_dq_oe         (sram_dq_oe)
   );

endmodule

// ==== dv/sram_model.sv ====
module sram_model (
   input  logic [cart_pkg::ADDR_W-2:0]   addr,
   input  logic                          ce_n,
   input  logic                          oe_n,
   input  logic                          we_n,
   input  logic [1:0]                    be_n,
   input  logic [cart_pkg::SRAM_W-1:0]   dq_in,
   input  logic                          dq_oe,
   output logic [cart_pkg::SRAM_W-1:0]   dq_out
);
   timeunit 1ns;
   timeprecision 100ps;

   import cart_pkg::*;

   localparam int DEPTH = 1 << (ADDR_W - 1);

   // Word array, bits 15..8 hold the even byte
   logic [SRAM_W-1:0] mem [DEPTH];

   // Write cycle captured while we_n is low
   logic [ADDR_W-2:0] wr_addr;
   logic [1:0]        wr_be_n = 2'b11;
   logic [SRAM_W-1:0] wr_data;

   // Blank part at power up
   initial begin
      for (int i = 0; i < DEPTH; i++)
         mem[i] = '0;
   end

   // Asynchronous read, bus idle when not enabled
   assign dq_out = (!ce_n && !oe_n && !dq_oe) ? mem[addr] : '0;

   // Hold address, lanes and data of the active write
   always_latch begin
      if (!ce_n && !we_n && dq_oe && be_n != 2'b11) begin
         wr_addr <= addr;
         wr_be_n <= be_n;
         wr_data <= dq_in;
      end
   end

   // Commit on the rising edge of we_n
   always @(posedge we_n) begin
      if (!wr_be_n[1])
         mem[wr_addr][SRAM_W-1:DATA_W] <= wr_data[SRAM_W-1:DATA_W];
      if (!wr_be_n[0])
         mem[wr_addr][DATA_W-1:0] <= wr_data[DATA_W-1:0];
   end

endmodule

// ==== dv/tb_cart_mem.sv ====
module tb_cart_mem;
   timeunit 1ns;
   timeprecision 100ps;

   import cart_pkg::*;

   // Console strobe hold and settle, in cycles
   localparam int SNES_HOLD    = 12;
   localparam int SNES_SETTLE  = 4;
   localparam int MCU_TIMEOUT  = 20;
   localparam int RESET_CYCLES = 4;

   localparam logic SIDE_SNES = 1'b0;
   localparam logic SIDE_MCU  = 1'b1;
   localparam logic OP_RD     = 1'b0;
   localparam logic OP_WR     = 1'b1;

   logic              CLK = 1'b0;
   logic              rst_n;
   logic              mode;
   logic              snes_rd_n;
   logic              snes_wr_n;
   logic [ADDR_W-1:0] snes_addr;
   logic [DATA_W-1:0] snes_data_in;
   logic [DATA_W-1:0] snes_data_out;
   logic              snes_data_oe;
   logic              mcu_rd;
   logic              mcu_wr;
   logic [ADDR_W-1:0] mcu_addr;
   logic [DATA_W-1:0] mcu_wdata;
   logic [DATA_W-1:0] mcu_rdata;
   logic              mcu_done;
   logic [ADDR_W-2:0] sram_addr;
   logic              sram_ce_n;
   logic              sram_oe_n;
   logic              sram_we_n;
   logic [1:0]        sram_be_n;
   logic [SRAM_W-1:0] sram_dq_out;
   logic              sram_dq_oe;
   logic [SRAM_W-1:0] sram_dq_in;

   // Stimulus table, one column per queue
   string             t_name[$];
   logic              t_mode[$];
   logic              t_side[$];
   logic              t_op[$];
   logic [ADDR_W-1:0] t_addr[$];
   logic [DATA_W-1:0] t_data[$];

   // Expected memory by byte address, unwritten bytes read as zero
   logic [DATA_W-1:0] ref_mem [int];

   int n_checks = 0;
   int n_errors = 0;
   int seed     = 48;

   always #4 CLK = ~CLK;

   cart_mem_top i_dut (
      .CLK           (CLK),
      .rst_n         (rst_n),
      .mode          (mode),
      .snes_rd_n     (snes_rd_n),
      .snes_wr_n     (snes_wr_n),
      .snes_addr     (snes_addr),
      .snes_data_in  (snes_data_in),
      .snes_data_out (snes_data_out),
      .snes_data_oe  (snes_data_oe),
      .mcu_rd        (mcu_rd),
      .mcu_wr        (mcu_wr),
      .mcu_addr      (mcu_addr),
      .mcu_wdata     (mcu_wdata),
      .mcu_rdata     (mcu_rdata),
      .mcu_done      (mcu_done),
      .sram_addr     (sram_addr),
      .sram_ce_n     (sram_ce_n),
      .sram_oe_n     (sram_oe_n),
      .sram_we_n     (sram_we_n),
      .sram_be_n     (sram_be_n),
      .sram_dq_out   (sram_dq_out),
      .sram_dq_oe    (sram_dq_oe),
      .sram_dq_in    (sram_dq_in)
   );

   sram_model i_sram (
      .addr   (sram_addr),
      .ce_n   (sram_ce_n),
      .oe_n   (sram_oe_n),
      .we_n   (sram_we_n),
      .be_n   (sram_be_n),
      .dq_in  (sram_dq_out),
      .dq_oe  (sram_dq_oe),
      .dq_out (sram_dq_in)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////////////////////

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      n_checks++;
      if (actual !== expected) begin
         n_errors++;
         $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
      end
   endtask

   function automatic logic [DATA_W-1:0] ref_byte(input logic [ADDR_W-1:0] addr);
      if (ref_mem.exists(int'(addr)))
         return ref_mem[int'(addr)];
      return '0;
   endfunction

   function automatic void add_entry(input string name, input logic m, input logic side,
                                     input logic op, input logic [ADDR_W-1:0] addr,
                                     input logic [DATA_W-1:0] data);
      t_name.push_back(name);
      t_mode.push_back(m);
      t_side.push_back(side);
      t_op.push_back(op);
      t_addr.push_back(addr);
      t_data.push_back(data);
   endfunction

   function automatic void build_table();
      // Basic MCU round trip
      add_entry("mcu_wr_a",     MODE_MCU,  SIDE_MCU,  OP_WR, 20'h00010, 8'h5a);
      add_entry("mcu_rd_a",     MODE_MCU,  SIDE_MCU,  OP_RD, 20'h00010, 8'h00);
      // Both lanes of one word
      add_entry("mcu_wr_even",  MODE_MCU,  SIDE_MCU,  OP_WR, 20'h01234, 8'($random(seed)));
      add_entry("mcu_wr_odd",   MODE_MCU,  SIDE_MCU,  OP_WR, 20'h01235, 8'($random(seed)));
      add_entry("mcu_rd_even",  MODE_MCU,  SIDE_MCU,  OP_RD, 20'h01234, 8'h00);
      add_entry("mcu_rd_odd",   MODE_MCU,  SIDE_MCU,  OP_RD, 20'h01235, 8'h00);
      add_entry("mcu_wr_even2", MODE_MCU,  SIDE_MCU,  OP_WR, 20'h01234, 8'($random(seed)));
      add_entry("mcu_rd_odd2",  MODE_MCU,  SIDE_MCU,  OP_RD, 20'h01235, 8'h00);
      add_entry("mcu_rd_even2", MODE_MCU,  SIDE_MCU,  OP_RD, 20'h01234, 8'h00);
      add_entry("mcu_wr_top",   MODE_MCU,  SIDE_MCU,  OP_WR, 20'hfffff, 8'($random(seed)));
      add_entry("mcu_rd_top",   MODE_MCU,  SIDE_MCU,  OP_RD, 20'hfffff, 8'h00);
      // Console to MCU and back
      add_entry("snes_wr_b",    MODE_SNES, SIDE_SNES, OP_WR, 20'h0abc7, 8'hc3);
      add_entry("mcu_rd_b",     MODE_MCU,  SIDE_MCU,  OP_RD, 20'h0abc7, 8'h00);
      add_entry("mcu_wr_c",     MODE_MCU,  SIDE_MCU,  OP_WR, 20'h0abc6, 8'($random(seed)));
      add_entry("snes_rd_c",    MODE_SNES, SIDE_SNES, OP_RD, 20'h0abc6, 8'h00);
      add_entry("snes_rd_b",    MODE_SNES, SIDE_SNES, OP_RD, 20'h0abc7, 8'h00);
      // Non-owner requests
      add_entry("snes_wr_ign",  MODE_MCU,  SIDE_SNES, OP_WR, 20'h00010, 8'hff);
      add_entry("mcu_wr_ign",   MODE_SNES, SIDE_MCU,  OP_WR, 20'h0abc7, 8'h11);
      add_entry("mcu_rd_ign",   MODE_SNES, SIDE_MCU,  OP_RD, 20'h00010, 8'h00);
      add_entry("mcu_rd_a2",    MODE_MCU,  SIDE_MCU,  OP_RD, 20'h00010, 8'h00);
      add_entry("snes_rd_b2",   MODE_SNES, SIDE_SNES, OP_RD, 20'h0abc7, 8'h00);
   endfunction

   // Model word must hold both bytes of the pair as the reference has them
   task automatic check_sram_word(input string name, input logic [ADDR_W-1:0] addr);
      logic [SRAM_W-1:0] exp_word;
      exp_word = {ref_byte({addr[ADDR_W-1:1], 1'b0}), ref_byte({addr[ADDR_W-1:1], 1'b1})};
      check_value({name, " word"}, 32'(exp_word), 32'(i_sram.mem[addr[ADDR_W-1:1]]));
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Bus cycles
   ////////////////////////////////////////////////////////////////////////////

   // One MCU pulse, then wait for mcu_done
   task automatic run_mcu(input int idx, input bit ignored);
      int                cycles;
      bit                seen;
      logic [DATA_W-1:0] exp_byte;
      exp_byte = ref_byte(t_addr[idx]);
      cycles   = 0;
      seen     = 1'b0;
      @(posedge CLK);
      mcu_addr  <= t_addr[idx];
      mcu_wdata <= t_data[idx];
      mcu_rd    <= (t_op[idx] == OP_RD);
      mcu_wr    <= (t_op[idx] == OP_WR);
      while (!seen && cycles < MCU_TIMEOUT) begin
         @(posedge CLK);
         mcu_rd <= 1'b0;
         mcu_wr <= 1'b0;
         cycles++;
         @(negedge CLK);
         if (mcu_done === 1'b1)
            seen = 1'b1;
      end
      if (ignored) begin
         if (seen) begin
            n_errors++;
            $display("%s: mcu_done came back for a request from the non-owner", t_name[idx]);
         end
      end else if (!seen) begin
         n_errors++;
         $display("%s: timed out waiting for mcu_done", t_name[idx]);
      end else begin
         check_value({t_name[idx], " latency"}, 32'(SRAM_WAIT + 1), 32'(cycles));
         if (t_op[idx] == OP_RD)
            check_value({t_name[idx], " rdata"}, 32'(exp_byte), 32'(mcu_rdata));
      end
   endtask

   // Console strobe held long enough for the whole access
   task automatic run_snes(input int idx, input bit ignored);
      logic [DATA_W-1:0] exp_byte;
      exp_byte = ref_byte(t_addr[idx]);
      @(posedge CLK);
      snes_addr    <= t_addr[idx];
      snes_data_in <= t_data[idx];
      if (t_op[idx] == OP_RD)
         snes_rd_n <= 1'b0;
      else
         snes_wr_n <= 1'b0;
      repeat (SNES_HOLD) @(posedge CLK);
      @(negedge CLK);
      if (t_op[idx] == OP_RD) begin
         check_value({t_name[idx], " oe"}, 32'(1), 32'(snes_data_oe));
         if (!ignored)
            check_value({t_name[idx], " data"}, 32'(exp_byte), 32'(snes_data_out));
      end else begin
         check_value({t_name[idx], " oe"}, 32'(0), 32'(snes_data_oe));
      end
      @(posedge CLK);
      snes_rd_n <= 1'b1;
      snes_wr_n <= 1'b1;
      @(negedge CLK);
      check_value({t_name[idx], " oe off"}, 32'(0), 32'(snes_data_oe));
      // Let the synchronizer see the release
      repeat (SNES_SETTLE) @(posedge CLK);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      bit ignored;
      rst_n        = 1'b0;
      mode         = MODE_MCU;
      snes_rd_n    = 1'b1;
      snes_wr_n    = 1'b1;
      snes_addr    = '0;
      snes_data_in = '0;
      mcu_rd       = 1'b0;
      mcu_wr       = 1'b0;
      mcu_addr     = '0;
      mcu_wdata    = '0;
      build_table();

      repeat (RESET_CYCLES) @(posedge CLK);
      rst_n <= 1'b1;
      @(negedge CLK);

      // Idle state out of reset
      check_value("reset ce_n", 32'(1), 32'(sram_ce_n));
      check_value("reset oe_n", 32'(1), 32'(sram_oe_n));
      check_value("reset we_n", 32'(1), 32'(sram_we_n));
      check_value("reset be_n", 32'(2'b11), 32'(sram_be_n));
      check_value("reset dq_oe", 32'(0), 32'(sram_dq_oe));
      check_value("reset mcu_done", 32'(0), 32'(mcu_done));
      check_value("reset mcu_rdata", 32'(0), 32'(mcu_rdata));

      for (int i = 0; i < t_name.size(); i++) begin
         // Only the owner side reaches the SRAM
         if (t_side[i] == SIDE_MCU)
            ignored = (t_mode[i] != MODE_MCU);
         else
            ignored = (t_mode[i] != MODE_SNES);
         @(posedge CLK);
         mode <= t_mode[i];
         if (t_side[i] == SIDE_MCU)
            run_mcu(i, ignored);
         else
            run_snes(i, ignored);
         if (t_op[i] == OP_WR) begin
            if (!ignored)
               ref_mem[int'(t_addr[i])] = t_data[i];
            check_sram_word(t_name[i], t_addr[i]);
         end
      end

      $display("Checks: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

// ==== sources.f ====
verilog/cart_pkg.sv
verilog/cart_data_path.sv
verilog/cart_mem_sequencer.sv
verilog/cart_mem_top.sv
dv/sram_model.sv
dv/tb_cart_mem.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the cart memory testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
   --top-module tb_cart_mem -f sources.f -o tb_cart_mem

./obj_dir/tb_cart_mem > sim.log 2>&1
cat sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
   exit 1
fi
exit 0
